/* filelist.f */
+incdir+hdl
+incdir+tb
hdl/sensor_cfg_pkg.sv
hdl/cfg_ctrl.sv
hdl/sccb_frame_gen.sv
hdl/sensor_config.sv
tb/sensor_config_tb.sv

/* hdl/cfg_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_ctrl import sensor_cfg_pkg::*; #(
    parameter int powerup_cycles = powerup_cycles_default
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       frame_done,
    output logic       frame_start,
    output cfg_entry_u entry,
    output logic       config_done
);

    typedef enum logic [1:0] {
        st_wait,                                    // Power-up delay
        st_start,                                   // Kick one frame
        st_busy,                                    // Frame on the bus
        st_done
    } state_t;

    typedef logic [$clog2(powerup_cycles + 1)-1:0] delay_cnt_t;

    state_t     state;
    state_t     state_nxt;
    delay_cnt_t delay_cnt;
    cfg_index_t index;
    logic       delay_end;
    logic       last_entry;

    assign delay_end  = (state == st_wait) && (delay_cnt == delay_cnt_t'(powerup_cycles - 1));
    assign last_entry = (index == cfg_index_t'(cfg_entries - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_wait;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_wait: begin
                if (delay_end) begin
                    state_nxt = st_start;
                end
            end
            st_start: begin
                state_nxt = st_busy;
            end
            st_busy: begin
                if (frame_done) begin
                    state_nxt = last_entry ? st_done : st_start;
                end
            end
            default: begin
                state_nxt = st_done;                // Table finished, stay here
            end
        endcase
    end

    // Only runs once after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            delay_cnt <= '0;
        end else if (state == st_wait && !delay_end) begin
            delay_cnt <= delay_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index <= '0;
        end else if (state == st_busy && frame_done && !last_entry) begin
            index <= index + 1'b1;
        end
    end

    assign entry       = cfg_table[index];          // Stable until frame_done
    assign frame_start = (state == st_start);
    assign config_done = (state == st_done);

endmodule

`default_nettype wire

/* hdl/sccb_frame_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module sccb_frame_gen import sensor_cfg_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       frame_start,
    input  cfg_entry_u entry,
    input  logic       done,
    output logic       req,
    output i2c_req_t   req_word,
    output logic       frame_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,                                     // Load the output register
        st_write                                    // Byte outstanding
    } state_t;

    state_t     state;
    state_t     state_nxt;
    logic [1:0] byte_cnt;
    logic       byte_acc;
    logic       last_byte;
    i2c_req_t   word_nxt;

    // Done only counts while a byte is in flight
    assign byte_acc   = (state == st_write) && done;
    assign last_byte  = (byte_cnt == 2'(frame_bytes - 1));
    assign frame_done = byte_acc && last_byte;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (frame_start) begin
                    state_nxt = st_req;
                end
            end
            st_req: begin
                state_nxt = st_write;
            end
            st_write: begin
                if (byte_acc) begin
                    state_nxt = last_byte ? st_idle : st_req;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= '0;
        end else if (byte_acc) begin
            byte_cnt <= byte_cnt + 2'd1;            // Wraps to the id byte after the data
        end
    end

    // Id first and then the entry in bus order
    always_comb begin
        word_nxt           = '0;
        word_nxt.cmd.write = 1'b1;
        case (byte_cnt)
            2'd0: begin
                word_nxt.cmd.start = 1'b1;
                word_nxt.data      = sccb_write_id;
            end
            2'd1: begin
                word_nxt.data = entry.bytes[0];     // Address high
            end
            2'd2: begin
                word_nxt.data = entry.bytes[1];     // Address low
            end
            default: begin
                word_nxt.cmd.stop = 1'b1;
                word_nxt.data     = entry.bytes[2];
            end
        endcase
    end

    // Single cycle request with the word zero outside it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req      <= 1'b0;
            req_word <= '0;
        end else if (state == st_req) begin
            req      <= 1'b1;
            req_word <= word_nxt;
        end else begin
            req      <= 1'b0;
            req_word <= '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/sensor_cfg_pkg.sv */
`default_nettype none

package sensor_cfg_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] reg_addr_t;

    // Flags decoded by the external byte master
    typedef struct packed {
        logic start;
        logic stop;
        logic read;                                 // Never set for a config write
        logic write;
    } i2c_cmd_t;

    // Travels with req for one cycle
    typedef struct packed {
        i2c_cmd_t cmd;
        byte_t    data;
    } i2c_req_t;

    typedef struct packed {
        reg_addr_t reg_addr;
        byte_t     reg_data;
    } cfg_entry_s;

    // One table word seen as fields or as bytes in bus order
    typedef union packed {
        cfg_entry_s        cfg;
        byte_t [0:2]       bytes;                   // [0] addr high, [2] data
    } cfg_entry_u;

    localparam byte_t sccb_write_id = 8'h78;        // Sensor write address

    localparam int cfg_entries = 32;
    typedef logic [$clog2(cfg_entries)-1:0] cfg_index_t;

    localparam int frame_bytes = 4;                 // Id, addr high, addr low, data

    // Sensor supply settle time at the system clock
    localparam int powerup_cycles_default = 1_000_000;

`include "sensor_cfg_table.svh"

endpackage

`default_nettype wire

/* hdl/sensor_cfg_table.svh */
`ifndef SENSOR_CFG_TABLE_SVH
`define SENSOR_CFG_TABLE_SVH

// Register writes in issue order, {reg_addr, reg_data}
localparam cfg_entry_u cfg_table [cfg_entries] = '{
    {16'h3103, 8'h11},                              // Clock from pad
    {16'h3008, 8'h82},                              // Soft reset
    {16'h3008, 8'h42},                              // Soft power down
    {16'h3103, 8'h03},                              // Clock from PLL
    {16'h3017, 8'hff},                              // Sync and upper data pins out
    {16'h3018, 8'hff},                              // Lower data pins out
    {16'h3034, 8'h1a},
    {16'h3037, 8'h13},                              // PLL root and pre divider
    {16'h3108, 8'h01},                              // PCLK and SCLK dividers
    {16'h3035, 8'h21},
    {16'h3036, 8'h69},                              // PLL multiplier
    {16'h3820, 8'h47},                              // Vertical flip
    {16'h3821, 8'h01},
    {16'h3814, 8'h31},                              // X increment
    {16'h3815, 8'h31},                              // Y increment
    {16'h3800, 8'h00},                              // Window X start
    {16'h3801, 8'h00},
    {16'h3802, 8'h00},                              // Window Y start
    {16'h3803, 8'hfa},
    {16'h3804, 8'h0a},                              // Window X end
    {16'h3805, 8'h3f},
    {16'h3806, 8'h06},                              // Window Y end
    {16'h3807, 8'ha9},
    {16'h3808, 8'h05},                              // Output width 1280
    {16'h3809, 8'h00},
    {16'h380a, 8'h02},                              // Output height 720
    {16'h380b, 8'hd0},
    {16'h380c, 8'h07},                              // Total line length
    {16'h380d, 8'h64},
    {16'h4300, 8'h61},                              // RGB565 output
    {16'h501f, 8'h01},                              // ISP in RGB mode
    {16'h3008, 8'h02}                               // Leave standby last
};

`endif

/* hdl/sensor_config.sv */
`timescale 1ns/1ps
`default_nettype none

module sensor_config import sensor_cfg_pkg::*; #(
    parameter int powerup_cycles = powerup_cycles_default
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     done,                          // From byte master
    output logic     req,
    output i2c_req_t req_word,
    output logic     config_done
);

    logic       frame_start;
    logic       frame_done;
    cfg_entry_u entry;

    // Table walk and power-up wait
    cfg_ctrl #(
        .powerup_cycles (powerup_cycles)
    ) i_cfg_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_done  (frame_done),
        .frame_start (frame_start),
        .entry       (entry),
        .config_done (config_done)
    );

    // Four byte commands per entry
    sccb_frame_gen i_sccb_frame_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .entry       (entry),
        .done        (done),
        .req         (req),
        .req_word    (req_word),
        .frame_done  (frame_done)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the sensor_config testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module sensor_config_tb \
    --Mdir obj_dir -o sensor_config_sim \
    -f filelist.f

./obj_dir/sensor_config_sim > sim.log
cat sim.log

if grep -F -q "*** TEST FAILED ***" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failure"

/* tb/sensor_config_tb_model.svh */
`ifndef SENSOR_CONFIG_TB_MODEL_SVH
`define SENSOR_CONFIG_TB_MODEL_SVH

i2c_req_t exp_q[$];                                 // Expected byte commands in bus order
int       mismatch_count = 0;
int       error_count    = 0;

function automatic i2c_req_t make_req(logic start, logic stop, byte_t data);
    i2c_req_t r;
    r           = '0;
    r.cmd.start = start;
    r.cmd.stop  = stop;
    r.cmd.write = 1'b1;                             // Every config byte is a write
    r.data      = data;
    return r;
endfunction

// Id, address high, address low, data for each table entry
task automatic build_expected();
    cfg_entry_u e;
    exp_q.delete();
    for (int i = 0; i < cfg_entries; i++) begin
        e = cfg_table[i];
        exp_q.push_back(make_req(1'b1, 1'b0, sccb_write_id));
        exp_q.push_back(make_req(1'b0, 1'b0, e.cfg.reg_addr[15:8]));
        exp_q.push_back(make_req(1'b0, 1'b0, e.cfg.reg_addr[7:0]));
        exp_q.push_back(make_req(1'b0, 1'b1, e.cfg.reg_data));
    end
endtask

task automatic check_req(string what, i2c_req_t actual, i2c_req_t expected);
    if (actual !== expected) begin
        mismatch_count++;
        $display("Mismatch at %0t: %s got cmd=%04b data=%02h, expected cmd=%04b data=%02h",
                 $time, what, actual.cmd, actual.data, expected.cmd, expected.data);
    end
endtask

task automatic check_flag(string what, logic actual, logic expected);
    if (actual !== expected) begin
        mismatch_count++;
        $display("Mismatch at %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
endtask

task automatic check_count(string what, int actual, int expected);
    if (actual != expected) begin
        mismatch_count++;
        $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
endtask

task automatic report_error(string msg);
    error_count++;
    $display("Error at %0t: %s", $time, msg);
endtask

`endif

/* tb/sensor_config_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sensor_config_tb import sensor_cfg_pkg::*; ();

    localparam int powerup_tb     = 200;            // Short power-up wait for simulation
    localparam int total_bytes    = cfg_entries * frame_bytes;
    localparam int idle_cycles    = 100;
    localparam int timeout_cycles = 2 * (powerup_tb + 4 + cfg_entries * 4 * 18);

    logic     clk = 1'b0;
    logic     rst_n;
    logic     done;
    logic     req;
    i2c_req_t req_word;
    logic     config_done;

    // Monitor state with cycles counted from reset release
    int cyc          = 0;
    int exp_idx      = 0;
    int acc_count    = 0;
    int next_req_cyc = 0;
    int done_cyc     = 0;
    bit expect_req   = 1'b0;
    bit outstanding  = 1'b0;
    bit done_due     = 1'b0;
    bit done_seen    = 1'b0;

`include "sensor_config_tb_model.svh"

    sensor_config #(
        .powerup_cycles (powerup_tb)
    ) i_sensor_config (
        .clk         (clk),
        .rst_n       (rst_n),
        .done        (done),
        .req         (req),
        .req_word    (req_word),
        .config_done (config_done)
    );

    always #50 clk = ~clk;                          // 100 ns period

    task automatic apply_reset();
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    // Byte master answering each req after 0 to 15 cycles
    task automatic answer_requests();
        int wait_cnt;
        bit busy;
        wait_cnt = 0;
        busy     = 1'b0;
        done     = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst_n) begin
                busy = 1'b0;
                done = 1'b0;
            end else begin
                if (req) begin
                    busy     = 1'b1;
                    wait_cnt = int'($urandom_range(15, 0));
                end
                if (busy && wait_cnt == 0) begin
                    done = 1'b1;
                    busy = 1'b0;
                end else if (busy) begin
                    done     = 1'b0;
                    wait_cnt = wait_cnt - 1;
                end else begin
                    done = ($urandom_range(9, 0) == 0);  // Stray pulse with nothing in flight
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            check_flag("req in reset", req, 1'b0);
            check_req("req_word in reset", req_word, '0);
            check_flag("config_done in reset", config_done, 1'b0);
            cyc          = 0;
            exp_idx      = 0;                       // Model starts over at entry 0
            acc_count    = 0;
            outstanding  = 1'b0;
            expect_req   = 1'b1;
            next_req_cyc = powerup_tb + 3;
            done_due     = 1'b0;
            done_seen    = 1'b0;
        end else begin
            cyc++;
            if (req) begin
                if (outstanding) begin
                    report_error("req rose while a byte was still outstanding");
                end
                if (!expect_req) begin
                    report_error("req came when none was due");
                end else begin
                    check_count("cycle of req", cyc, next_req_cyc);
                end
                if (exp_idx < total_bytes) begin
                    check_req($sformatf("byte %0d of entry %0d", exp_idx % frame_bytes,
                                        exp_idx / frame_bytes), req_word, exp_q[exp_idx]);
                    exp_idx++;
                end else begin
                    report_error("req after the last table entry");
                end
                outstanding = 1'b1;
                expect_req  = 1'b0;
            end else begin
                check_req("req_word between requests", req_word, '0);
                if (expect_req && cyc >= next_req_cyc) begin
                    report_error("expected req did not appear");
                    expect_req = 1'b0;
                end
            end
            // Done only counts with a byte in flight
            if (outstanding && done) begin
                outstanding = 1'b0;
                acc_count++;
                if (acc_count == total_bytes) begin
                    done_due = 1'b1;
                    done_cyc = cyc + 1;
                end else begin
                    expect_req   = 1'b1;
                    next_req_cyc = cyc + ((acc_count % frame_bytes == 0) ? 3 : 2);
                end
            end
            check_flag("config_done", config_done, done_due && cyc >= done_cyc);
            if (config_done && !done_seen) begin
                done_seen = 1'b1;
                check_count("bytes written", exp_idx, total_bytes);
            end
        end
    end

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: configuration still running after %0d cycles", timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : main_seq
        int cut;
        rst_n = 1'b1;
        void'($urandom(9164));
        fork
            answer_requests();
        join_none
        build_expected();
        #1 rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        wait (config_done);
        repeat (idle_cycles) @(posedge clk);       // No req may show up here

        // Second pass cut short by a reset at a random point
        apply_reset();
        cut = powerup_tb + 10 + int'($urandom_range(790, 0));
        repeat (cut) @(posedge clk);
        apply_reset();
        wait (config_done);
        repeat (idle_cycles) @(posedge clk);

        $display("Summary: %0d mismatches, %0d other errors", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
